//--- gencon.f
design/gencon_pkg.sv
design/gencon_arith_if.sv
design/sm_addsub.sv
design/sm_multiply.sv
design/gencon_ctrl.sv
design/gencon_top.sv
verification/gencon_chk.sv
verification/gencon_tb.sv

//--- Bender.yml
package:
  name: gencon

sources:
  - design/gencon_pkg.sv
  - design/gencon_arith_if.sv
  - design/sm_addsub.sv
  - design/sm_multiply.sv
  - design/gencon_ctrl.sv
  - design/gencon_top.sv
  - target: test
    files:
      - verification/gencon_chk.sv
      - verification/gencon_tb.sv

//--- verification/gencon_tb.sv
// Keypad calculator testbench with reference model, result monitor and timeout
`default_nettype none

module gencon_tb;

    localparam int RAND_EXPR      = 200;
    localparam int MAX_EXPR_KEYS  = 14;
    localparam int DIRECTED_KEYS  = 90;
    localparam int TIMEOUT_CYCLES = 40 * (DIRECTED_KEYS + RAND_EXPR * MAX_EXPR_KEYS) + 200;

    logic                 clk = 1'b0;
    logic                 nRST;
    logic [3:0]           keypad_input;
    logic                 read_input;
    logic [2:0]           operator_input;
    logic                 equal_input;
    logic                 ready;
    logic                 complete;
    gencon_pkg::sm_word_t display_output;

    gencon_pkg::sm_word_t exp_q[$];
    int                   error_count = 0;
    int                   check_count = 0;
    int                   done_count  = 0;
    int                   cycle_count = 0;

    gencon_top i_dut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .ready          (ready),
        .complete       (complete),
        .display_output (display_output)
    );

    always #10 clk = ~clk;

    // Sign-magnitude result of one expression, magnitudes wrap modulo 2^15
    function automatic gencon_pkg::sm_word_t calc_expected(input gencon_pkg::sm_word_t a,
                                                           input gencon_pkg::sm_word_t b,
                                                           input gencon_pkg::op_code_t op);
        int                   mag;
        logic                 b_sign;
        gencon_pkg::sm_word_t res;
        b_sign = (op == gencon_pkg::OP_SUB) ? ~b.sign : b.sign;
        if (op == gencon_pkg::OP_MUL) begin
            mag      = (int'(a.mag) * int'(b.mag)) % (1 << gencon_pkg::MAG_W);
            res.sign = a.sign ^ b.sign;
        end else if (a.sign == b_sign) begin
            mag      = (int'(a.mag) + int'(b.mag)) % (1 << gencon_pkg::MAG_W);
            res.sign = a.sign;
        end else if (a.mag >= b.mag) begin
            mag      = int'(a.mag) - int'(b.mag);
            res.sign = a.sign;
        end else begin
            mag      = int'(b.mag) - int'(a.mag);
            res.sign = b_sign;
        end
        res.mag = mag[gencon_pkg::MAG_W-1:0];
        if (mag == 0) begin
            res.sign = 1'b0;
        end
        return res;
    endfunction

    task automatic check_word(input string name, input gencon_pkg::sm_word_t expected,
                              input gencon_pkg::sm_word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t %s expected %s%0d actual %s%0d", $time, name,
                     expected.sign ? "-" : "+", expected.mag,
                     actual.sign ? "-" : "+", actual.mag);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    // Results in order of the equal presses
    always @(posedge clk) begin
        if (nRST && complete) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("Completion at %0t with no expression pending", $time);
            end else begin
                check_word("display_output", exp_q.pop_front(), display_output);
            end
            done_count++;
        end
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
        $display("Simulation FAILED");
        $finish;
    end

    // Key tasks start and end on a falling edge
    task automatic wait_ready();
        while (!ready) begin
            @(negedge clk);
        end
    endtask

    task automatic press_digit(input logic [3:0] d);
        wait_ready();
        keypad_input = d;
        read_input   = 1'b1;
        @(negedge clk);
        read_input   = 1'b0;
    endtask

    task automatic press_op(input gencon_pkg::op_code_t op);
        wait_ready();
        operator_input = op;
        @(negedge clk);
        operator_input = gencon_pkg::OP_NONE;
    endtask

    task automatic press_equal();
        wait_ready();
        equal_input = 1'b1;
        @(negedge clk);
        equal_input = 1'b0;
    endtask

    task automatic enter_number(input string digits, input logic negate,
                                output gencon_pkg::sm_word_t entered);
        int         mag;
        int         i;
        logic [3:0] d;
        mag = 0;
        if (negate) begin
            press_op(gencon_pkg::OP_NEG);
        end
        for (i = 0; i < digits.len(); i++) begin
            d = 4'(digits[i] - 8'h30);
            press_digit(d);
            mag = (mag * gencon_pkg::DIGIT_BASE + d) % (1 << gencon_pkg::MAG_W);
        end
        entered.sign = negate;
        entered.mag  = mag[gencon_pkg::MAG_W-1:0];
    endtask

    task automatic run_expr(input string a, input logic neg_a, input gencon_pkg::op_code_t op,
                            input string b, input logic neg_b);
        gencon_pkg::sm_word_t a_w;
        gencon_pkg::sm_word_t b_w;
        int                   target;
        enter_number(a, neg_a, a_w);
        press_op(op);
        enter_number(b, neg_b, b_w);
        exp_q.push_back(calc_expected(a_w, b_w, op));
        target = done_count + 1;
        press_equal();
        while (done_count < target) begin
            @(negedge clk);
        end
    endtask

    function automatic string random_digits();
        string s;
        int    len;
        s   = "";
        len = $urandom_range(5, 1);
        for (int i = 0; i < len; i++) begin
            s = $sformatf("%s%0d", s, $urandom_range(9, 0));
        end
        return s;
    endfunction

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errs_before);
        end
    endtask

    initial begin
        int                   errs;
        int                   n;
        string                a_str;
        string                b_str;
        logic                 neg_a;
        logic                 neg_b;
        gencon_pkg::op_code_t op;
        void'($urandom(17134));
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = gencon_pkg::OP_NONE;
        equal_input    = 1'b0;
        repeat (10) @(negedge clk);
        nRST = 1'b1;

        errs = error_count;
        check_bit("ready", 1'b1, ready);
        check_bit("complete", 1'b0, complete);
        check_word("display_output", '0, display_output);
        // Equal with no operator must do nothing
        press_equal();
        repeat (40) @(negedge clk);
        check_bit("ready", 1'b1, ready);
        report_test("reset_and_lone_equal", errs);

        errs = error_count;
        run_expr("123", 1'b0, gencon_pkg::OP_ADD, "4567", 1'b0);
        run_expr("9999", 1'b0, gencon_pkg::OP_ADD, "0", 1'b0);
        report_test("multi_digit_add", errs);

        errs = error_count;
        run_expr("25", 1'b0, gencon_pkg::OP_SUB, "300", 1'b0);
        run_expr("7", 1'b1, gencon_pkg::OP_SUB, "7", 1'b1);
        run_expr("300", 1'b0, gencon_pkg::OP_SUB, "25", 1'b0);
        report_test("subtract_signs", errs);

        errs = error_count;
        run_expr("12", 1'b1, gencon_pkg::OP_MUL, "34", 1'b0);
        run_expr("12", 1'b0, gencon_pkg::OP_MUL, "34", 1'b1);
        run_expr("12", 1'b1, gencon_pkg::OP_MUL, "34", 1'b1);
        run_expr("200", 1'b0, gencon_pkg::OP_MUL, "200", 1'b0);
        run_expr("123456", 1'b0, gencon_pkg::OP_MUL, "1", 1'b0);
        report_test("multiply_and_wrap", errs);

        errs = error_count;
        run_expr("5", 1'b0, gencon_pkg::OP_ADD, "6", 1'b0);
        run_expr("7", 1'b0, gencon_pkg::OP_MUL, "8", 1'b0);
        run_expr("9", 1'b0, gencon_pkg::OP_SUB, "10", 1'b0);
        report_test("back_to_back", errs);

        errs = error_count;
        for (n = 0; n < RAND_EXPR; n++) begin
            a_str = random_digits();
            neg_a = 1'($urandom_range(1, 0));
            b_str = random_digits();
            neg_b = 1'($urandom_range(1, 0));
            case ($urandom_range(2, 0))
                0: op = gencon_pkg::OP_ADD;
                1: op = gencon_pkg::OP_SUB;
                default: op = gencon_pkg::OP_MUL;
            endcase
            run_expr(a_str, neg_a, op, b_str, neg_b);
        end
        report_test("random_expressions", errs);

        $display("%0d checks, %0d errors, %0d assertion failures", check_count, error_count,
                 i_dut.u_ctrl.i_chk.fail_count);
        if (error_count == 0 && i_dut.u_ctrl.i_chk.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/gencon_chk.sv
// Handshake assertions for the calculator controller and its two arithmetic units
`default_nettype none

module gencon_chk (
    input logic clk,
    input logic nRST,
    input logic ready,
    input logic complete,
    input logic add_start,
    input logic add_finish,
    input logic mul_start,
    input logic mul_finish
);

    int unsigned fail_count = 0;

    logic add_pend;
    logic mul_pend;

    // Outstanding request per unit
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            add_pend <= 1'b0;
            mul_pend <= 1'b0;
        end else begin
            if (add_start) begin
                add_pend <= 1'b1;
            end else if (add_finish) begin
                add_pend <= 1'b0;
            end
            if (mul_start) begin
                mul_pend <= 1'b1;
            end else if (mul_finish) begin
                mul_pend <= 1'b0;
            end
        end
    end

    complete_one_cycle: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
    else begin
        $error("complete stayed high for more than one cycle");
        fail_count++;
    end

    add_start_idle: assert property (@(posedge clk) disable iff (!nRST)
        add_start |-> !add_pend)
    else begin
        $error("start sent to the adder before its finish");
        fail_count++;
    end

    mul_start_idle: assert property (@(posedge clk) disable iff (!nRST)
        mul_start |-> !mul_pend)
    else begin
        $error("start sent to the multiplier before its finish");
        fail_count++;
    end

    add_finish_owed: assert property (@(posedge clk) disable iff (!nRST)
        add_finish |-> add_pend)
    else begin
        $error("adder finish without an outstanding start");
        fail_count++;
    end

    mul_finish_owed: assert property (@(posedge clk) disable iff (!nRST)
        mul_finish |-> mul_pend)
    else begin
        $error("multiplier finish without an outstanding start");
        fail_count++;
    end

    // Never accept keys while showing a result
    busy_on_complete: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> !ready)
    else begin
        $error("ready high together with complete");
        fail_count++;
    end

endmodule

bind gencon_ctrl gencon_chk i_chk (
    .clk        (clk),
    .nRST       (nRST),
    .ready      (ready),
    .complete   (complete),
    .add_start  (add_bus.start),
    .add_finish (add_bus.finish),
    .mul_start  (mul_bus.start),
    .mul_finish (mul_bus.finish)
);

`default_nettype wire

//--- design/gencon_top.sv
// Keypad calculator top level joining the controller, adder and multiplier
`default_nettype none

module gencon_top (
    input  logic                 clk,
    input  logic                 nRST,

    // Keypad side
    input  logic [3:0]           keypad_input,
    input  logic                 read_input,
    input  logic [2:0]           operator_input,
    input  logic                 equal_input,

    // Display side
    output logic                 ready,
    output logic                 complete,
    output gencon_pkg::sm_word_t display_output
);

    gencon_arith_if add_bus ();
    gencon_arith_if mul_bus ();

    gencon_ctrl u_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (gencon_pkg::op_code_t'(operator_input)),
        .equal_input    (equal_input),
        .ready          (ready),
        .complete       (complete),
        .display_output (display_output),
        .add_bus        (add_bus.ctrl),
        .mul_bus        (mul_bus.ctrl)
    );

    // Add and subtract
    sm_addsub u_addsub (
        .clk  (clk),
        .nRST (nRST),
        .bus  (add_bus.addsub_unit)
    );

    // Digit times-ten and final products
    sm_multiply u_multiply (
        .clk  (clk),
        .nRST (nRST),
        .bus  (mul_bus.mul_unit)
    );

endmodule

`default_nettype wire

//--- design/gencon_ctrl.sv
// Calculator controller for digit entry, sign toggle, operator latch and dispatch
`default_nettype none

module gencon_ctrl (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic [3:0]           keypad_input,
    input  logic                 read_input,
    input  gencon_pkg::op_code_t operator_input,
    input  logic                 equal_input,
    output logic                 ready,
    output logic                 complete,
    output gencon_pkg::sm_word_t display_output,
    gencon_arith_if.ctrl         add_bus,
    gencon_arith_if.ctrl         mul_bus
);

    gencon_pkg::ctrl_state_t state;
    gencon_pkg::ctrl_state_t next_state;

    gencon_pkg::sm_word_t op1_q;
    gencon_pkg::sm_word_t op2_q;
    gencon_pkg::op_code_t op_q;

    logic [3:0]                   digit_q;
    logic [gencon_pkg::MAG_W-1:0] entry_mag;
    logic                         neg_key;
    logic                         binop_key;
    logic                         digit_go;
    logic                         send_mul;

    assign neg_key   = (operator_input == gencon_pkg::OP_NEG);
    assign binop_key = operator_input inside {gencon_pkg::OP_ADD, gencon_pkg::OP_SUB,
                                              gencon_pkg::OP_MUL};

    // A read accepted this cycle starts a times-ten on the multiplier
    assign digit_go  = (state == gencon_pkg::WAIT_OP1 && next_state == gencon_pkg::WAIT_MULT_OP1)
                    || (state == gencon_pkg::WAIT_OP2 && next_state == gencon_pkg::WAIT_MULT_OP2);
    assign entry_mag = (state == gencon_pkg::WAIT_OP1) ? op1_q.mag : op2_q.mag;
    assign send_mul  = (state == gencon_pkg::SEND_TO_COMPUTE) && (op_q == gencon_pkg::OP_MUL);

    always_comb begin
        next_state = state;
        case (state)
            gencon_pkg::WAIT_OP1: begin
                if (binop_key) begin
                    next_state = gencon_pkg::WAIT_OP2;
                end else if (!neg_key && read_input) begin
                    next_state = gencon_pkg::WAIT_MULT_OP1;
                end
            end
            gencon_pkg::WAIT_MULT_OP1: begin
                if (mul_bus.finish) begin
                    next_state = gencon_pkg::ADD_KEY_OP1;
                end
            end
            gencon_pkg::ADD_KEY_OP1: next_state = gencon_pkg::WAIT_OP1;
            gencon_pkg::WAIT_OP2: begin
                // Only OP_NEG acts here, it blocks read and equal
                if (!neg_key) begin
                    if (read_input) begin
                        next_state = gencon_pkg::WAIT_MULT_OP2;
                    end else if (equal_input) begin
                        next_state = gencon_pkg::SEND_TO_COMPUTE;
                    end
                end
            end
            gencon_pkg::WAIT_MULT_OP2: begin
                if (mul_bus.finish) begin
                    next_state = gencon_pkg::ADD_KEY_OP2;
                end
            end
            gencon_pkg::ADD_KEY_OP2: next_state = gencon_pkg::WAIT_OP2;
            gencon_pkg::SEND_TO_COMPUTE: next_state = gencon_pkg::WAIT_COMPUTE;
            gencon_pkg::WAIT_COMPUTE: begin
                if (add_bus.finish) begin
                    next_state = gencon_pkg::SHOW_RESULT_ADDSUB;
                end else if (mul_bus.finish) begin
                    next_state = gencon_pkg::SHOW_RESULT_MUL;
                end
            end
            default: next_state = gencon_pkg::WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= gencon_pkg::WAIT_OP1;
            op1_q          <= '0;
            op2_q          <= '0;
            op_q           <= gencon_pkg::OP_NONE;
            display_output <= '0;
            add_bus.start  <= 1'b0;
            mul_bus.start  <= 1'b0;
        end else begin
            state         <= next_state;
            add_bus.start <= (state == gencon_pkg::SEND_TO_COMPUTE) && !send_mul;
            mul_bus.start <= digit_go || send_mul;
            case (state)
                gencon_pkg::WAIT_OP1: begin
                    if (neg_key) begin
                        op1_q.sign <= ~op1_q.sign;
                    end else if (binop_key) begin
                        op_q <= operator_input;
                    end
                end
                gencon_pkg::WAIT_MULT_OP1: begin
                    if (mul_bus.finish) begin
                        op1_q.mag <= mul_bus.result.mag;
                    end
                end
                gencon_pkg::ADD_KEY_OP1: begin
                    op1_q.mag <= op1_q.mag + (gencon_pkg::MAG_W)'(digit_q);
                end
                gencon_pkg::WAIT_OP2: begin
                    if (neg_key) begin
                        op2_q.sign <= ~op2_q.sign;
                    end
                end
                gencon_pkg::WAIT_MULT_OP2: begin
                    if (mul_bus.finish) begin
                        op2_q.mag <= mul_bus.result.mag;
                    end
                end
                gencon_pkg::ADD_KEY_OP2: begin
                    op2_q.mag <= op2_q.mag + (gencon_pkg::MAG_W)'(digit_q);
                end
                gencon_pkg::WAIT_COMPUTE: begin
                    if (add_bus.finish) begin
                        display_output <= add_bus.result;
                    end else if (mul_bus.finish) begin
                        display_output <= mul_bus.result;
                    end
                end
                gencon_pkg::SHOW_RESULT_ADDSUB, gencon_pkg::SHOW_RESULT_MUL: begin
                    // Next expression starts from +0
                    op1_q <= '0;
                    op2_q <= '0;
                    op_q  <= gencon_pkg::OP_NONE;
                end
                default: ;
            endcase
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (digit_go) begin
            digit_q            <= keypad_input;
            mul_bus.op_a.sign  <= 1'b0;
            mul_bus.op_a.mag   <= entry_mag;
            mul_bus.op_b.sign  <= 1'b0;
            mul_bus.op_b.mag   <= (gencon_pkg::MAG_W)'(gencon_pkg::DIGIT_BASE);
        end else if (state == gencon_pkg::SEND_TO_COMPUTE) begin
            add_bus.op_a <= op1_q;
            add_bus.op_b <= op2_q;
            add_bus.sub  <= (op_q == gencon_pkg::OP_SUB);
            mul_bus.op_a <= op1_q;
            mul_bus.op_b <= op2_q;
        end
    end

    assign mul_bus.sub = 1'b0;

    assign ready    = (state == gencon_pkg::WAIT_OP1) || (state == gencon_pkg::WAIT_OP2);
    assign complete = (state == gencon_pkg::SHOW_RESULT_ADDSUB)
                   || (state == gencon_pkg::SHOW_RESULT_MUL);

endmodule

`default_nettype wire

//--- design/sm_multiply.sv
// Shift-add sign-magnitude multiplier, one multiplier bit per cycle
`default_nettype none

module sm_multiply (
    input logic              clk,
    input logic              nRST,
    gencon_arith_if.mul_unit bus
);

    logic [gencon_pkg::MAG_W-1:0] mcand_q;
    logic [gencon_pkg::MAG_W-1:0] mplier_q;
    logic [gencon_pkg::MAG_W-1:0] acc_q;
    logic [gencon_pkg::MAG_W-1:0] acc_d;

    logic [$clog2(gencon_pkg::MAG_W)-1:0] count_q;
    logic                                 last_step;
    logic                                 busy_q;
    logic                                 finish_q;
    logic                                 sign_q;

    gencon_pkg::sm_word_t result_q;

    // Partial product, upper bits fall off so the product wraps
    assign acc_d     = mplier_q[0] ? acc_q + mcand_q : acc_q;
    assign last_step = busy_q && (count_q == gencon_pkg::MAG_W - 1);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy_q   <= 1'b0;
            finish_q <= 1'b0;
            count_q  <= '0;
        end else begin
            finish_q <= 1'b0;
            if (bus.start) begin
                busy_q  <= 1'b1;
                count_q <= '0;
            end else if (busy_q) begin
                count_q <= count_q + 1'b1;
                if (last_step) begin
                    busy_q   <= 1'b0;
                    finish_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            mcand_q  <= bus.op_a.mag;
            mplier_q <= bus.op_b.mag;
            acc_q    <= '0;
            sign_q   <= bus.op_a.sign ^ bus.op_b.sign;
        end else if (busy_q) begin
            acc_q    <= acc_d;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
            if (last_step) begin
                result_q.mag  <= acc_d;
                // Zero product is always positive
                result_q.sign <= sign_q & (|acc_d);
            end
        end
    end

    assign bus.result = result_q;
    assign bus.finish = finish_q;

endmodule

`default_nettype wire

//--- design/sm_addsub.sv
// Sign-magnitude adder/subtractor with a fixed two-cycle start to finish latency
`default_nettype none

module sm_addsub (
    input logic                 clk,
    input logic                 nRST,
    gencon_arith_if.addsub_unit bus
);

    gencon_pkg::sm_word_t a_q;
    gencon_pkg::sm_word_t b_q;
    gencon_pkg::sm_word_t sum_d;
    gencon_pkg::sm_word_t result_q;

    logic [gencon_pkg::MAG_W-1:0]      mag_d;
    logic [gencon_pkg::ADDSUB_LAT-1:0] stage;

    // Operand capture, subtract handled by flipping the sign of op_b
    always_ff @(posedge clk) begin
        if (bus.start) begin
            a_q        <= bus.op_a;
            b_q.sign   <= bus.op_b.sign ^ bus.sub;
            b_q.mag    <= bus.op_b.mag;
        end
    end

    always_comb begin
        if (a_q.sign == b_q.sign) begin
            mag_d      = a_q.mag + b_q.mag;
            sum_d.sign = a_q.sign;
        end else if (a_q.mag >= b_q.mag) begin
            mag_d      = a_q.mag - b_q.mag;
            sum_d.sign = a_q.sign;
        end else begin
            mag_d      = b_q.mag - a_q.mag;
            sum_d.sign = b_q.sign;
        end
        sum_d.mag = mag_d;
        // No negative zero
        if (mag_d == '0) begin
            sum_d.sign = 1'b0;
        end
    end

    // Start travels down the stage chain, last bit is finish
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            stage <= '0;
        end else begin
            stage <= {stage[gencon_pkg::ADDSUB_LAT-2:0], bus.start};
        end
    end

    always_ff @(posedge clk) begin
        if (stage[gencon_pkg::ADDSUB_LAT-2]) begin
            result_q <= sum_d;
        end
    end

    assign bus.result = result_q;
    assign bus.finish = stage[gencon_pkg::ADDSUB_LAT-1];

endmodule

`default_nettype wire

//--- design/gencon_arith_if.sv
// Arithmetic request/result bus between the calculator controller and one unit
`default_nettype none

interface gencon_arith_if;

    // Request
    gencon_pkg::sm_word_t op_a;
    gencon_pkg::sm_word_t op_b;
    logic                 sub;
    logic                 start;

    // Completion, result held until the next start
    gencon_pkg::sm_word_t result;
    logic                 finish;

    modport ctrl (
        output op_a, op_b, sub, start,
        input  result, finish
    );

    modport addsub_unit (
        input  op_a, op_b, sub, start,
        output result, finish
    );

    // Multiplier has no use for sub
    modport mul_unit (
        input  op_a, op_b, start,
        output result, finish
    );

endinterface

`default_nettype wire

//--- design/gencon_pkg.sv
// Calculator package holding number format, operator codes and controller states
`default_nettype none

package gencon_pkg;

    // Number format
    localparam int DATA_W = 16;
    localparam int MAG_W = DATA_W - 1;

    // Digit entry radix
    localparam int DIGIT_BASE = 10;

    // Cycles from start to finish in the adder
    localparam int ADDSUB_LAT = 2;

    // Sign-magnitude word, sign on top
    typedef struct packed {
        logic             sign;
        logic [MAG_W-1:0] mag;
    } sm_word_t;

    // Keypad operator codes, 5 to 7 unused
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_code_t;

    typedef enum logic [3:0] {
        WAIT_OP1,
        WAIT_MULT_OP1,
        ADD_KEY_OP1,
        WAIT_OP2,
        WAIT_MULT_OP2,
        ADD_KEY_OP2,
        SEND_TO_COMPUTE,
        WAIT_COMPUTE,
        SHOW_RESULT_ADDSUB,
        SHOW_RESULT_MUL
    } ctrl_state_t;

endpackage

`default_nettype wire
